// File: design/cmdproc_defines.svh
`ifndef CMDPROC_DEFINES_SVH
`define CMDPROC_DEFINES_SVH

// ====================
// Command FIFO format
// ====================

// One FIFO word, four words per command
`define CMDPROC_WORD_W          32
`define CMDPROC_WORDS_PER_CMD   4

// Header word: opcode in 7:0, ID in 15:8
`define CMDPROC_OP_W            8
`define CMDPROC_ID_W            8

// WAIT_DISP target ID, low bits of payload word 1
`define CMDPROC_WAIT_ID_BIT     0

// ====================
// Engine parameters
// ====================

// FETCH: address is all of word 1, length and target in word 2
`define CMDPROC_LINK_ADDR_W     32
`define CMDPROC_LINK_LEN_W      16
`define CMDPROC_FETCH_LEN_LSB   0
`define CMDPROC_FETCH_TARGET_BIT 16

// DISP: tile address, length and mantissa flag packed in word 1
`define CMDPROC_TILE_ADDR_W     11
`define CMDPROC_DISP_ADDR_LSB   0
`define CMDPROC_DISP_LEN_LSB    11
`define CMDPROC_DISP_MAN_BIT    22

`endif

// File: design/cmdproc_cmd_pkg.sv
`default_nettype none

`include "cmdproc_defines.svh"

package cmdproc_cmd_pkg;

    // Opcodes understood by the sequencer
    // Anything else is dropped
    typedef enum logic [`CMDPROC_OP_W-1:0] {
        CMD_OP_FETCH     = `CMDPROC_OP_W'(1),
        CMD_OP_DISP      = `CMDPROC_OP_W'(2),
        CMD_OP_WAIT_DISP = `CMDPROC_OP_W'(4)
    } cmd_op_e;

    // Command ID carried in the header
    typedef logic [`CMDPROC_ID_W-1:0] cmd_id_t;

    // Header word layout, MSB first
    typedef struct packed {
        logic [`CMDPROC_WORD_W-`CMDPROC_ID_W-`CMDPROC_OP_W-1:0] rsvd;
        cmd_id_t                                              id;
        cmd_op_e                                              op;
    } cmd_hdr_t;

    // Whole command as read from the FIFO
    // Index 0 is the header, 1..3 are payload
    typedef logic [`CMDPROC_WORDS_PER_CMD-1:0][`CMDPROC_WORD_W-1:0] cmd_words_t;

endpackage : cmdproc_cmd_pkg

`default_nettype wire

// File: design/cmdproc_engine_pkg.sv
`default_nettype none

`include "cmdproc_defines.svh"

package cmdproc_engine_pkg;

    // Memory fetch launch, 49 bits
    typedef struct packed {
        logic [`CMDPROC_LINK_ADDR_W-1:0] addr;
        logic [`CMDPROC_LINK_LEN_W-1:0]  len;
        // Set selects the right-hand target
        logic                            target;
    } fetch_params_t;

    // Tile-memory dispatch launch, 23 bits
    typedef struct packed {
        logic [`CMDPROC_TILE_ADDR_W-1:0] addr;
        logic [`CMDPROC_TILE_ADDR_W-1:0] len;
        // 4-bit mantissa when set, 8-bit otherwise
        logic                            man_4b;
    } disp_params_t;

endpackage : cmdproc_engine_pkg

`default_nettype wire

// File: design/cmd_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmdproc_defines.svh"

module cmd_reader
    import cmdproc_cmd_pkg::*;
(
    input  wire logic                       i_clk,
    input  wire logic                       i_reset_n,
    input  wire logic [`CMDPROC_WORD_W-1:0] i_cmd_fifo_rdata,
    input  wire logic                       i_cmd_fifo_empty,
    input  wire logic                       i_result_afull,
    input  wire logic                       i_cmd_done,
    output logic                            o_cmd_fifo_ren,
    output logic                            o_cmd_valid,
    output cmd_words_t                      o_cmd_words
);

    localparam int unsigned CNT_W = $clog2(`CMDPROC_WORDS_PER_CMD);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`CMDPROC_WORDS_PER_CMD - 1);

    // Read window open, strobes still owed
    logic             ren_q;
    // Command in flight between start and valid
    logic             active_q;
    // Strobe of last cycle, data is on rdata now
    logic             pend_q;
    logic [CNT_W-1:0] rd_cnt_q;
    logic [CNT_W-1:0] wr_idx_q;
    logic             start;
    logic             strobe;

    // Start only when empty-handed and the result side has room
    assign start  = !active_q && !o_cmd_valid && !i_cmd_fifo_empty && !i_result_afull;

    // Never pop an empty FIFO
    assign strobe = ren_q && !i_cmd_fifo_empty;
    assign o_cmd_fifo_ren = strobe;

    // ====================
    // Read control
    // ====================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            ren_q       <= 1'b0;
            active_q    <= 1'b0;
            pend_q      <= 1'b0;
            rd_cnt_q    <= '0;
            wr_idx_q    <= '0;
            o_cmd_valid <= 1'b0;
        end else begin
            // Registered FIFO, so capture one cycle behind the strobe
            pend_q <= strobe;

            if (start) begin
                active_q <= 1'b1;
                ren_q    <= 1'b1;
            end

            // Close the window after the last word's strobe
            if (strobe) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
                if (rd_cnt_q == LAST_WORD) begin
                    ren_q <= 1'b0;
                end
            end

            if (pend_q) begin
                wr_idx_q <= wr_idx_q + 1'b1;
                // Last word lands, command is complete
                if (wr_idx_q == LAST_WORD) begin
                    active_q    <= 1'b0;
                    o_cmd_valid <= 1'b1;
                end
            end

            // Held until the sequencer is finished with it
            if (i_cmd_done) begin
                o_cmd_valid <= 1'b0;
            end
        end
    end

    // Word storage, header in slot 0
    always_ff @(posedge i_clk) begin
        if (pend_q) begin
            o_cmd_words[wr_idx_q] <= i_cmd_fifo_rdata;
        end
    end

endmodule : cmd_reader

`default_nettype wire

// File: design/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmdproc_defines.svh"

module cmd_sequencer
    import cmdproc_cmd_pkg::*;
    import cmdproc_engine_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,
    input  wire logic       i_cmd_valid,
    input  wire cmd_words_t i_cmd_words,
    input  wire logic       i_dc_busy,
    input  wire logic       i_dc_fetch_done,
    output logic            o_cmd_done,
    output logic            o_fetch_launch,
    output fetch_params_t   o_fetch_params,
    output logic            o_disp_launch,
    output disp_params_t    o_disp_params
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECODE,
        ST_FETCH_LAUNCH,
        ST_FETCH_WAIT,
        ST_DISP,
        ST_WAIT_DISP,
        ST_COMPLETE
    } state_e;

    state_e                     state_q;
    state_e                     state_d;
    cmd_hdr_t                   hdr;
    logic [`CMDPROC_WORD_W-1:0] word1;
    logic [`CMDPROC_WORD_W-1:0] word2;
    cmd_id_t                    wait_id;
    cmd_id_t                    last_disp_id_q;
    logic                       fetch_go;

    // ====================
    // Field slicing
    // ====================
    assign hdr   = cmd_hdr_t'(i_cmd_words[0]);
    assign word1 = i_cmd_words[1];
    assign word2 = i_cmd_words[2];

    assign wait_id = word1[`CMDPROC_WAIT_ID_BIT +: `CMDPROC_ID_W];

    // Words stay put while valid, so the slices are stable at launch
    assign o_fetch_params = '{
        addr:   word1[`CMDPROC_LINK_ADDR_W-1:0],
        len:    word2[`CMDPROC_FETCH_LEN_LSB +: `CMDPROC_LINK_LEN_W],
        target: word2[`CMDPROC_FETCH_TARGET_BIT]
    };

    assign o_disp_params = '{
        addr:   word1[`CMDPROC_DISP_ADDR_LSB +: `CMDPROC_TILE_ADDR_W],
        len:    word1[`CMDPROC_DISP_LEN_LSB +: `CMDPROC_TILE_ADDR_W],
        man_4b: word1[`CMDPROC_DISP_MAN_BIT]
    };

    // Dispatcher must be idle before a fetch goes out
    assign fetch_go = (state_q == ST_FETCH_LAUNCH) && !i_dc_busy;

    // ====================
    // FSM
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_cmd_valid) begin
                    state_d = ST_DECODE;
                end
            end
            ST_DECODE: begin
                case (hdr.op)
                    CMD_OP_FETCH:     state_d = ST_FETCH_LAUNCH;
                    CMD_OP_DISP:      state_d = ST_DISP;
                    CMD_OP_WAIT_DISP: state_d = ST_WAIT_DISP;
                    // Unknown opcode, drop it
                    default:          state_d = ST_COMPLETE;
                endcase
            end
            ST_FETCH_LAUNCH: begin
                if (fetch_go) begin
                    state_d = ST_FETCH_WAIT;
                end
            end
            ST_FETCH_WAIT: begin
                if (i_dc_fetch_done) begin
                    state_d = ST_COMPLETE;
                end
            end
            ST_DISP: begin
                state_d = ST_COMPLETE;
            end
            ST_WAIT_DISP: begin
                // No timeout, blocks until a later DISP catches up
                if (last_disp_id_q >= wait_id) begin
                    state_d = ST_COMPLETE;
                end
            end
            ST_COMPLETE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q        <= ST_IDLE;
            o_fetch_launch <= 1'b0;
            o_disp_launch  <= 1'b0;
            last_disp_id_q <= '0;
        end else begin
            state_q        <= state_d;
            // One-cycle launch pulses
            o_fetch_launch <= fetch_go;
            o_disp_launch  <= (state_q == ST_DECODE) && (hdr.op == CMD_OP_DISP);
            // ID counts as issued once the launch is out
            if (state_q == ST_DISP) begin
                last_disp_id_q <= hdr.id;
            end
        end
    end

    // Releases the reader for the next command
    assign o_cmd_done = (state_q == ST_COMPLETE);

endmodule : cmd_sequencer

`default_nettype wire

// File: design/engine_launch.sv
`timescale 1ns/1ps
`default_nettype none

module engine_launch #(
    parameter type payload_t = logic
) (
    input  wire logic     i_clk,
    input  wire logic     i_reset_n,
    input  wire logic     i_launch,
    input  wire payload_t i_params,
    output logic          o_en,
    output payload_t      o_params
);

    // ====================
    // Launch register
    // ====================

    // Enable and parameters move on the same edge
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_en <= 1'b0;
        end else begin
            // One cycle high per launch
            o_en <= i_launch;
        end
    end

    // Parameters hold until the next launch
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_params <= '0;
        end else if (i_launch) begin
            o_params <= i_params;
        end
    end

endmodule : engine_launch

`default_nettype wire

// File: design/command_processor.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmdproc_defines.svh"

module command_processor
    import cmdproc_cmd_pkg::*;
    import cmdproc_engine_pkg::*;
(
    input  wire logic                            i_clk,
    input  wire logic                            i_reset_n,
    // Command FIFO
    input  wire logic [`CMDPROC_WORD_W-1:0]      i_cmd_fifo_rdata,
    input  wire logic                            i_cmd_fifo_empty,
    output logic                                 o_cmd_fifo_ren,
    // Result side back-pressure
    input  wire logic                            i_result_afull,
    // Dispatcher
    input  wire logic                            i_dc_busy,
    input  wire logic                            i_dc_fetch_done,
    output logic                                 o_dc_fetch_en,
    output logic [`CMDPROC_LINK_ADDR_W-1:0]      o_dc_fetch_addr,
    output logic [`CMDPROC_LINK_LEN_W-1:0]       o_dc_fetch_len,
    output logic                                 o_dc_fetch_target,
    output logic                                 o_dc_disp_en,
    output logic [`CMDPROC_TILE_ADDR_W-1:0]      o_dc_disp_addr,
    output logic [`CMDPROC_TILE_ADDR_W-1:0]      o_dc_disp_len,
    output logic                                 o_dc_man_4b
);

    logic          cmd_valid;
    logic          cmd_done;
    cmd_words_t    cmd_words;
    logic          fetch_launch;
    logic          disp_launch;
    fetch_params_t fetch_params;
    disp_params_t  disp_params;
    fetch_params_t fetch_out;
    disp_params_t  disp_out;

    // ====================
    // Command path
    // ====================
    cmd_reader cmd_reader_inst (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_cmd_fifo_rdata (i_cmd_fifo_rdata),
        .i_cmd_fifo_empty (i_cmd_fifo_empty),
        .i_result_afull   (i_result_afull),
        .i_cmd_done       (cmd_done),
        .o_cmd_fifo_ren   (o_cmd_fifo_ren),
        .o_cmd_valid      (cmd_valid),
        .o_cmd_words      (cmd_words)
    );

    cmd_sequencer cmd_sequencer_inst (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cmd_valid     (cmd_valid),
        .i_cmd_words     (cmd_words),
        .i_dc_busy       (i_dc_busy),
        .i_dc_fetch_done (i_dc_fetch_done),
        .o_cmd_done      (cmd_done),
        .o_fetch_launch  (fetch_launch),
        .o_fetch_params  (fetch_params),
        .o_disp_launch   (disp_launch),
        .o_disp_params   (disp_params)
    );

    // ====================
    // Launch ports
    // ====================
    engine_launch #(.payload_t(fetch_params_t)) fetch_launch_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_launch  (fetch_launch),
        .i_params  (fetch_params),
        .o_en      (o_dc_fetch_en),
        .o_params  (fetch_out)
    );

    engine_launch #(.payload_t(disp_params_t)) disp_launch_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_launch  (disp_launch),
        .i_params  (disp_params),
        .o_en      (o_dc_disp_en),
        .o_params  (disp_out)
    );

    // Struct fields out to the dispatcher pins
    assign o_dc_fetch_addr   = fetch_out.addr;
    assign o_dc_fetch_len    = fetch_out.len;
    assign o_dc_fetch_target = fetch_out.target;
    assign o_dc_disp_addr    = disp_out.addr;
    assign o_dc_disp_len     = disp_out.len;
    assign o_dc_man_4b       = disp_out.man_4b;

endmodule : command_processor

`default_nettype wire

// File: verification/command_processor_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module command_processor_assertions (
    input wire logic i_clk,
    input wire logic i_reset_n,
    input wire logic i_cmd_fifo_ren,
    input wire logic i_cmd_fifo_empty,
    input wire logic i_dc_fetch_en,
    input wire logic i_dc_disp_en,
    input wire logic i_dc_busy
);

    // ====================
    // Command FIFO
    // ====================

    // Popping an empty FIFO would shift every later word
    property no_read_when_empty;
        @(posedge i_clk) disable iff (!i_reset_n)
            i_cmd_fifo_ren |-> !i_cmd_fifo_empty;
    endproperty

    read_when_empty_a : assert property (no_read_when_empty)
        else $error("command FIFO read strobe while empty");

    // ====================
    // Dispatcher
    // ====================

    // One launch at a time
    property enables_exclusive;
        @(posedge i_clk) disable iff (!i_reset_n)
            !(i_dc_fetch_en && i_dc_disp_en);
    endproperty

    enables_exclusive_a : assert property (enables_exclusive)
        else $error("fetch and dispatch enables high together");

    // Fetch only goes out to an idle dispatcher
    property fetch_not_busy;
        @(posedge i_clk) disable iff (!i_reset_n)
            i_dc_fetch_en |-> !i_dc_busy;
    endproperty

    fetch_not_busy_a : assert property (fetch_not_busy)
        else $error("fetch enable while dispatcher busy");

endmodule : command_processor_assertions

`default_nettype wire

// File: verification/command_processor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module command_processor_tb;

    localparam int MAX_TESTS = 32;
    localparam int CLK_HALF  = 20;
    localparam int SETTLE    = 10;

    logic        i_clk;
    logic        i_reset_n;
    logic [31:0] i_cmd_fifo_rdata;
    logic        i_cmd_fifo_empty;
    logic        i_result_afull;
    logic        i_dc_busy;
    logic        i_dc_fetch_done;
    logic        o_cmd_fifo_ren;
    logic        o_dc_fetch_en;
    logic [31:0] o_dc_fetch_addr;
    logic [15:0] o_dc_fetch_len;
    logic        o_dc_fetch_target;
    logic        o_dc_disp_en;
    logic [10:0] o_dc_disp_addr;
    logic [10:0] o_dc_disp_len;
    logic        o_dc_man_4b;

    // Test table, one entry per file line
    string       t_name  [MAX_TESTS];
    logic [31:0] t_word  [MAX_TESTS][4];
    int          t_busy  [MAX_TESTS];
    int          t_afull [MAX_TESTS];
    string       t_kind  [MAX_TESTS];
    logic [31:0] t_exp   [MAX_TESTS][3];
    int          num_tests = 0;
    logic        loaded    = 1'b0;

    // FIFO and dispatcher models
    logic [31:0] fifo_q[$];
    int          busy_left  = 0;
    int          afull_left = 0;
    int          done_wait  = 0;
    logic [31:0] rng_state  = 32'd93;

    // Monitor state, updated on the rising edge
    logic        ren_seen          = 1'b0;
    logic        fetch_seen        = 1'b0;
    logic        fetch_outstanding = 1'b0;
    int          strobe_cnt        = 0;
    int          fetch_cnt         = 0;
    int          disp_cnt          = 0;
    int          done_cnt          = 0;
    logic [31:0] cap_fetch_addr;
    logic [15:0] cap_fetch_len;
    logic        cap_fetch_target;
    logic [10:0] cap_disp_addr;
    logic [10:0] cap_disp_len;
    logic        cap_disp_man;
    int          value_errors      = 0;
    int          proto_errors      = 0;

    command_processor command_processor_inst (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_cmd_fifo_rdata  (i_cmd_fifo_rdata),
        .i_cmd_fifo_empty  (i_cmd_fifo_empty),
        .o_cmd_fifo_ren    (o_cmd_fifo_ren),
        .i_result_afull    (i_result_afull),
        .i_dc_busy         (i_dc_busy),
        .i_dc_fetch_done   (i_dc_fetch_done),
        .o_dc_fetch_en     (o_dc_fetch_en),
        .o_dc_fetch_addr   (o_dc_fetch_addr),
        .o_dc_fetch_len    (o_dc_fetch_len),
        .o_dc_fetch_target (o_dc_fetch_target),
        .o_dc_disp_en      (o_dc_disp_en),
        .o_dc_disp_addr    (o_dc_disp_addr),
        .o_dc_disp_len     (o_dc_disp_len),
        .o_dc_man_4b       (o_dc_man_4b)
    );

    bind command_processor command_processor_assertions command_processor_assertions_inst (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_cmd_fifo_ren   (o_cmd_fifo_ren),
        .i_cmd_fifo_empty (i_cmd_fifo_empty),
        .i_dc_fetch_en    (o_dc_fetch_en),
        .i_dc_disp_en     (o_dc_disp_en),
        .i_dc_busy        (i_dc_busy)
    );

    initial i_clk = 1'b0;
    always #CLK_HALF i_clk = ~i_clk;

    // 32-bit xorshift for the fetch-done delay
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ====================
    // Input drivers
    // ====================
    always @(negedge i_clk) begin
        // Registered FIFO, word shows up the cycle after the strobe
        if (ren_seen && fifo_q.size() > 0) begin
            i_cmd_fifo_rdata = fifo_q.pop_front();
        end
        i_cmd_fifo_empty = (fifo_q.size() == 0);
        i_dc_busy        = (busy_left > 0);
        i_result_afull   = (afull_left > 0);
        if (busy_left > 0) begin
            busy_left = busy_left - 1;
        end
        if (afull_left > 0) begin
            afull_left = afull_left - 1;
        end
        // Dispatcher answers each fetch after 1 to 8 cycles
        i_dc_fetch_done = 1'b0;
        if (fetch_seen) begin
            rng_state = next_random(rng_state);
            done_wait = 1 + rng_state[2:0];
        end else if (done_wait > 0) begin
            done_wait = done_wait - 1;
            if (done_wait == 0) begin
                i_dc_fetch_done = 1'b1;
            end
        end
    end

    // ====================
    // Output monitor
    // ====================
    always @(posedge i_clk) begin
        ren_seen   <= (o_cmd_fifo_ren === 1'b1);
        fetch_seen <= (o_dc_fetch_en === 1'b1);
        if (i_reset_n) begin
            if (o_cmd_fifo_ren) begin
                strobe_cnt <= strobe_cnt + 1;
            end
            if (o_dc_fetch_en) begin
                fetch_cnt         <= fetch_cnt + 1;
                fetch_outstanding <= 1'b1;
                cap_fetch_addr    <= o_dc_fetch_addr;
                cap_fetch_len     <= o_dc_fetch_len;
                cap_fetch_target  <= o_dc_fetch_target;
            end
            if (o_dc_disp_en) begin
                disp_cnt      <= disp_cnt + 1;
                cap_disp_addr <= o_dc_disp_addr;
                cap_disp_len  <= o_dc_disp_len;
                cap_disp_man  <= o_dc_man_4b;
            end
            if (i_dc_fetch_done) begin
                done_cnt          <= done_cnt + 1;
                fetch_outstanding <= 1'b0;
            end
            // Protocol rules, same as the bound assertions
            if (o_cmd_fifo_ren && fetch_outstanding) begin
                $display("Read strobe for the next command came before the fetch was done");
                proto_errors <= proto_errors + 1;
            end
            if (o_cmd_fifo_ren && i_cmd_fifo_empty) begin
                $display("Read strobe while the command FIFO was empty");
                proto_errors <= proto_errors + 1;
            end
            if (o_dc_fetch_en && o_dc_disp_en) begin
                $display("Fetch and dispatch enables were high together");
                proto_errors <= proto_errors + 1;
            end
            if (o_dc_fetch_en && i_dc_busy) begin
                $display("Fetch enable while the dispatcher was busy");
                proto_errors <= proto_errors + 1;
            end
        end
    end

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s, %s: expected 0x%0h, actual 0x%0h",
                     test, field, expected, actual);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          cnt;
        int          busy;
        int          afull;
        string       line;
        string       name;
        string       kind;
        logic [31:0] w [4];
        logic [31:0] e [3];
        fd = $fopen("verification/command_processor_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file");
            value_errors = value_errors + 1;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank lines and the column notes
                if (line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %d %d %s %h %h %h", name,
                                  w[0], w[1], w[2], w[3], busy, afull, kind, e[0], e[1], e[2]);
                    if (cnt == 11) begin
                        t_name[num_tests]  = name;
                        t_word[num_tests]  = w;
                        t_busy[num_tests]  = busy;
                        t_afull[num_tests] = afull;
                        t_kind[num_tests]  = kind;
                        t_exp[num_tests]   = e;
                        num_tests = num_tests + 1;
                    end else begin
                        $display("Malformed line in the test file: %s", line);
                        value_errors = value_errors + 1;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) begin
            $display("No tests were loaded");
            value_errors = value_errors + 1;
        end
        loaded = 1'b1;
    endtask

    task automatic wait_strobes(input int target);
        while (strobe_cnt < target) begin
            @(posedge i_clk);
        end
    endtask

    // Header opcode 0xf0 is not a known command
    task automatic push_unknown_command();
        fifo_q.push_back(32'h0000_00f0);
        fifo_q.push_back(32'h0);
        fifo_q.push_back(32'h0);
        fifo_q.push_back(32'h0);
    endtask

    task automatic reset_dut(input string test);
        @(posedge i_clk);
        fifo_q.delete();
        busy_left  = 0;
        afull_left = 0;
        @(negedge i_clk);
        i_reset_n = 1'b0;
        repeat (10) @(negedge i_clk);
        // Idle outputs while reset is still held
        compare_value(test, "reset ren", 0, o_cmd_fifo_ren);
        compare_value(test, "reset fetch_en", 0, o_dc_fetch_en);
        compare_value(test, "reset fetch_addr", 0, o_dc_fetch_addr);
        compare_value(test, "reset fetch_len", 0, o_dc_fetch_len);
        compare_value(test, "reset fetch_target", 0, o_dc_fetch_target);
        compare_value(test, "reset disp_en", 0, o_dc_disp_en);
        compare_value(test, "reset disp_addr", 0, o_dc_disp_addr);
        compare_value(test, "reset disp_len", 0, o_dc_disp_len);
        compare_value(test, "reset man_4b", 0, o_dc_man_4b);
        i_reset_n = 1'b1;
    endtask

    // ====================
    // One command per test
    // ====================
    task automatic run_test(input int n);
        int    base_strobe;
        int    base_fetch;
        int    base_disp;
        int    base_done;
        int    i;
        string kind;
        kind = t_kind[n];
        @(posedge i_clk);
        base_strobe = strobe_cnt;
        base_fetch  = fetch_cnt;
        base_disp   = disp_cnt;
        base_done   = done_cnt;
        // Header and word 1 first
        for (i = 0; i < 2; i++) begin
            fifo_q.push_back(t_word[n][i]);
        end
        busy_left  = t_busy[n];
        afull_left = t_afull[n];
        if (t_afull[n] > 0) begin
            repeat (t_afull[n]) @(posedge i_clk);
            compare_value(t_name[n], "strobes under afull", 0, strobe_cnt - base_strobe);
        end
        wait_strobes(base_strobe + 2);
        // FIFO has run dry mid-command, rest of the words follow
        for (i = 2; i < 4; i++) begin
            fifo_q.push_back(t_word[n][i]);
        end
        wait_strobes(base_strobe + 4);
        if (kind == "fetch") begin
            // Next command waits in the FIFO until the fetch is done
            push_unknown_command();
            while (fetch_cnt - base_fetch < 1) begin
                @(posedge i_clk);
            end
            while (done_cnt - base_done < 1) begin
                @(posedge i_clk);
            end
            wait_strobes(base_strobe + 8);
        end else if (kind == "disp") begin
            while (disp_cnt - base_disp < 1) begin
                @(posedge i_clk);
            end
        end else if (kind == "block") begin
            push_unknown_command();
            repeat (50) @(posedge i_clk);
        end
        repeat (SETTLE) @(posedge i_clk);
        compare_value(t_name[n], "strobes", (kind == "fetch") ? 8 : 4,
                      strobe_cnt - base_strobe);
        compare_value(t_name[n], "fetch enables", (kind == "fetch") ? 1 : 0,
                      fetch_cnt - base_fetch);
        compare_value(t_name[n], "disp enables", (kind == "disp") ? 1 : 0,
                      disp_cnt - base_disp);
        if (kind == "fetch") begin
            compare_value(t_name[n], "fetch_addr", t_exp[n][0], cap_fetch_addr);
            compare_value(t_name[n], "fetch_len", t_exp[n][1], cap_fetch_len);
            compare_value(t_name[n], "fetch_target", t_exp[n][2], cap_fetch_target);
        end else if (kind == "disp") begin
            compare_value(t_name[n], "disp_addr", t_exp[n][0], cap_disp_addr);
            compare_value(t_name[n], "disp_len", t_exp[n][1], cap_disp_len);
            compare_value(t_name[n], "man_4b", t_exp[n][2], cap_disp_man);
        end else if (kind == "block") begin
            reset_dut(t_name[n]);
        end
    endtask

    initial begin
        int n;
        i_reset_n        = 1'b0;
        i_cmd_fifo_rdata = '0;
        i_cmd_fifo_empty = 1'b1;
        i_result_afull   = 1'b0;
        i_dc_busy        = 1'b0;
        i_dc_fetch_done  = 1'b0;
        load_tests();
        reset_dut("initial");
        for (n = 0; n < num_tests; n++) begin
            run_test(n);
        end
        $display("Value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog, budget scales with the number of tests
    initial begin
        wait (loaded === 1'b1);
        repeat ((num_tests + 1) * 200) @(posedge i_clk);
        $display("Timeout: the run did not finish within %0d cycles", (num_tests + 1) * 200);
        $display("tests failed");
        $finish;
    end

endmodule : command_processor_tb

`default_nettype wire

// File: verification/command_processor_tests.txt
# name header word1 word2 word3 busy_cycles afull_cycles kind exp_a exp_b exp_c (words hex)
# fetch: addr len target, disp: addr len man_4b, none: no enable, block: wait blocks then reset
fetch_basic 00000301 80001000 00010040 00000000 0 0 fetch 80001000 0040 1
fetch_busy 00000401 12345678 0000abcd 11111111 12 0 fetch 12345678 abcd 0
disp_id5 00000502 ffd51955 00000000 22222222 0 0 disp 155 2a3 1
wait_eq5 00000004 00000005 00000000 00000000 0 0 none 0 0 0
wait_lt5 00000104 12345603 00000000 00000000 0 3 none 0 0 0
disp_id6 00000602 00000fff 00000000 33333333 0 0 disp 7ff 001 0
disp_id5b 00000502 00800001 44444444 00000000 0 0 disp 001 000 0
wait_gt5_block 00000004 00000007 00000000 00000000 0 0 block 0 0 0
wait_zero_after_reset 00000004 00000000 00000000 00000000 0 0 none 0 0 0
wait_one_block 00000004 00000001 00000000 00000000 0 0 block 0 0 0
unknown_afull 000007aa 55555555 66666666 77777777 0 6 none 0 0 0
disp_afull 00000802 007ff800 00000000 00000000 0 9 disp 000 7ff 1
unknown_op3 00000903 00000001 00000002 00000003 0 0 none 0 0 0
fetch_after_unknown 00000a01 deadbeef fffe1234 00000000 3 2 fetch deadbeef 1234 0

// File: command_processor.f
+incdir+design
design/cmdproc_cmd_pkg.sv
design/cmdproc_engine_pkg.sv
design/cmd_reader.sv
design/cmd_sequencer.sv
design/engine_launch.sv
design/command_processor.sv
verification/command_processor_assertions.sv
verification/command_processor_tb.sv

// File: Bender.yml
package:
  name: command_processor

sources:
  - include_dirs:
      - design
    files:
      - design/cmdproc_cmd_pkg.sv
      - design/cmdproc_engine_pkg.sv
      - design/cmd_reader.sv
      - design/cmd_sequencer.sv
      - design/engine_launch.sv
      - design/command_processor.sv
  - target: simulation
    files:
      - verification/command_processor_assertions.sv
      - verification/command_processor_tb.sv
